// File: mmu_pkg.sv
package mmu_pkg;

    // address and data paths
    typedef logic [31:0] addr_t;      // virtual or physical
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;   // all zero on a read
    typedef logic [1:0]  axi_size_t;

    // access sizes as seen on the bus
    localparam axi_size_t SIZE_BYTE = 2'd0;
    localparam axi_size_t SIZE_HALF = 2'd1;
    localparam axi_size_t SIZE_WORD = 2'd2;

    // tlb entry fields, 4 KB pages
    typedef logic [18:0] vpn2_t;      // even/odd page pair
    typedef logic [19:0] pfn_t;
    typedef logic [7:0]  asid_t;

    // cache attribute, same encoding as Config.K0 and the EntryLo C field
    typedef logic [2:0] cattr_t;

    localparam cattr_t CATTR_UNCACHED = 3'd2;
    localparam cattr_t CATTR_CACHED   = 3'd3;

    // top three bits of a virtual address
    typedef logic [2:0] seg_t;

    localparam seg_t SEG_KSEG0 = 3'b100;  // unmapped
    localparam seg_t SEG_KSEG1 = 3'b101;  // unmapped, never cached
    // anything else goes through the tlb

    // ram wait counter for uncached accesses
    typedef enum logic [1:0] {
        WS_IDLE,
        WS_WAIT1,
        WS_WAIT2
    } wait_state_t;

endpackage

// File: mmu.sv
`timescale 1ns/10ps

module mmu import mmu_pkg::*; (
    input  logic      en,
    input  byte_en_t  wen,
    input  addr_t     vaddr,
    input  word_t     wdata,
    output word_t     rdata,
    input  axi_size_t size,

    input  logic      exc_flag,
    input  logic      erl,
    input  cattr_t    k0,
    input  cattr_t    k23,
    input  cattr_t    ku,

    output logic      bus_en,
    output byte_en_t  bus_wen,
    output addr_t     bus_paddr,
    output word_t     bus_wdata,
    input  word_t     bus_rdata,
    output axi_size_t bus_size,
    input  logic      bus_streq,
    output logic      bus_cached,

    output logic      tlb_en,
    output addr_t     tlb_vaddr,
    output logic      tlb_refs,
    input  logic      tlb_rdy,
    input  addr_t     tlb_paddr,
    input  logic      tlb_cat,
    input  logic      tlb_tlbr,
    input  logic      tlb_tlbi,
    input  logic      tlb_tlbm,

    output logic      exc_tlbr,
    output logic      exc_tlbi,
    output logic      exc_tlbm,
    output logic      stallreq
);

    seg_t   seg;
    logic   mapped;      // translation needed
    logic   tlb_exc;
    logic   tlb_streq;   // waiting on the registered lookup
    cattr_t seg_cat;     // attribute of the unmapped window

    assign seg    = seg_t'(vaddr[31:29]);
    assign mapped = !(seg == SEG_KSEG0 || seg == SEG_KSEG1) && !erl;

    always_comb begin
        case (seg)
            SEG_KSEG0: seg_cat = k0;
            SEG_KSEG1: seg_cat = CATTR_UNCACHED;
            default:   seg_cat = seg[2] ? k23 : ku;  // kseg2/3 or kuseg
        endcase
    end

    // tlb side, only touched for mapped segments
    assign tlb_en    = en && mapped;
    assign tlb_vaddr = tlb_en ? vaddr : '0;
    assign tlb_refs  = tlb_en && (wen != '0);  // store, for the dirty check
    assign tlb_exc   = tlb_tlbr || tlb_tlbi || tlb_tlbm;
    assign tlb_streq = tlb_en && !tlb_rdy;

    assign exc_tlbr = tlb_en && tlb_tlbr;
    assign exc_tlbi = tlb_en && tlb_tlbi;
    assign exc_tlbm = tlb_en && tlb_tlbm;

    // bus side
    always_comb begin
        if (mapped) begin
            bus_en     = en && !exc_flag && tlb_rdy && !tlb_exc;
            bus_paddr  = tlb_paddr;
            bus_cached = tlb_cat;
        end else begin
            // kseg0/kseg1 window, or the ERL bypass of a mapped segment
            bus_en     = en && !exc_flag;
            bus_paddr  = {3'b000, vaddr[28:0]};
            bus_cached = (seg_cat == CATTR_CACHED) && !erl;  // ERL forces uncached
        end
    end

    assign bus_wen   = en ? wen : '0;
    assign bus_wdata = wdata;
    assign bus_size  = size;
    assign rdata     = en ? bus_rdata : '0;

    assign stallreq = bus_streq || tlb_streq;

    // the core sees one exception cause at most
    always_comb begin
        assert final ($onehot0({exc_tlbr, exc_tlbi, exc_tlbm}))
            else $error("mmu: more than one tlb exception at once");
    end

endmodule

// File: tlb.sv
`timescale 1ns/10ps

module tlb import mmu_pkg::*; #(
    parameter  int TLB_ENTRIES = 8,
    localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
    input  logic             clk,
    input  logic             arst_n,

    // lookup
    input  logic             tlb_en,
    input  addr_t            tlb_vaddr,
    input  logic             tlb_refs,
    input  asid_t            asid,

    // indexed write
    input  logic             tlb_we,
    input  logic [IDX_W-1:0] tlb_index,
    input  vpn2_t            tlb_vpn2,
    input  asid_t            tlb_asid,
    input  logic             tlb_g,
    input  pfn_t             tlb_pfn0,
    input  pfn_t             tlb_pfn1,
    input  cattr_t           tlb_c0,
    input  cattr_t           tlb_c1,
    input  logic             tlb_d0,
    input  logic             tlb_d1,
    input  logic             tlb_v0,
    input  logic             tlb_v1,

    // result, one cycle after the request
    output logic             tlb_rdy,
    output addr_t            tlb_paddr,
    output logic             tlb_cat,
    output logic             tlb_tlbr,
    output logic             tlb_tlbi,
    output logic             tlb_tlbm
);

    // entry storage
    vpn2_t  ent_vpn2 [TLB_ENTRIES];
    asid_t  ent_asid [TLB_ENTRIES];
    logic   ent_g    [TLB_ENTRIES];
    pfn_t   ent_pfn0 [TLB_ENTRIES];
    pfn_t   ent_pfn1 [TLB_ENTRIES];
    cattr_t ent_c0   [TLB_ENTRIES];
    cattr_t ent_c1   [TLB_ENTRIES];
    logic   ent_d0   [TLB_ENTRIES];
    logic   ent_d1   [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] ent_v0;
    logic [TLB_ENTRIES-1:0] ent_v1;
    logic [TLB_ENTRIES-1:0] ent_used;  // written since reset

    // parallel compare
    logic [TLB_ENTRIES-1:0] hit_vec;
    logic                   hit;
    pfn_t                   sel_pfn;
    cattr_t                 sel_c;
    logic                   sel_d;
    logic                   sel_v;

    // registered lookup
    logic        look_q;
    logic        hit_q;
    pfn_t        pfn_q;
    cattr_t      c_q;
    logic        d_q;
    logic        v_q;
    logic [19:0] vpn_q;  // vaddr[31:12] of the registered lookup

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            ent_vpn2[tlb_index] <= tlb_vpn2;
            ent_asid[tlb_index] <= tlb_asid;
            ent_g[tlb_index]    <= tlb_g;
            ent_pfn0[tlb_index] <= tlb_pfn0;
            ent_pfn1[tlb_index] <= tlb_pfn1;
            ent_c0[tlb_index]   <= tlb_c0;
            ent_c1[tlb_index]   <= tlb_c1;
            ent_d0[tlb_index]   <= tlb_d0;
            ent_d1[tlb_index]   <= tlb_d1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_v0   <= '0;
            ent_v1   <= '0;
            ent_used <= '0;
        end else if (tlb_we) begin
            ent_v0[tlb_index]   <= tlb_v0;
            ent_v1[tlb_index]   <= tlb_v1;
            ent_used[tlb_index] <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_vec[i] = ent_used[i]
                      && (ent_vpn2[i] == tlb_vaddr[31:13])
                      && (ent_g[i] || ent_asid[i] == asid);
        end
    end

    // pick the hit entry, bit 12 chooses even or odd page
    always_comb begin
        hit     = 1'b0;
        sel_pfn = '0;
        sel_c   = '0;
        sel_d   = 1'b0;
        sel_v   = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                hit = 1'b1;
                if (tlb_vaddr[12]) begin
                    sel_pfn = ent_pfn1[i];
                    sel_c   = ent_c1[i];
                    sel_d   = ent_d1[i];
                    sel_v   = ent_v1[i];
                end else begin
                    sel_pfn = ent_pfn0[i];
                    sel_c   = ent_c0[i];
                    sel_d   = ent_d0[i];
                    sel_v   = ent_v0[i];
                end
            end
        end
    end

    // a write in the same cycle makes the stored result stale, so look again
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            look_q <= 1'b0;
        end else begin
            look_q <= tlb_en && !tlb_we;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_en) begin
            hit_q <= hit;
            pfn_q <= sel_pfn;
            c_q   <= sel_c;
            d_q   <= sel_d;
            v_q   <= sel_v;
            vpn_q <= tlb_vaddr[31:12];
        end
    end

    assign tlb_rdy   = look_q && tlb_en && (tlb_vaddr[31:12] == vpn_q);
    assign tlb_paddr = {pfn_q, tlb_vaddr[11:0]};
    assign tlb_cat   = (c_q == CATTR_CACHED);

    assign tlb_tlbr = tlb_rdy && !hit_q;                          // refill
    assign tlb_tlbi = tlb_rdy && hit_q && !v_q;                   // invalid page
    assign tlb_tlbm = tlb_rdy && hit_q && v_q && !d_q && tlb_refs; // store to clean page

    // duplicates would come from the write port, lookups must see one hit at most
    a_single_hit: assert property (
        @(posedge clk) disable iff (!arst_n) tlb_en |-> $onehot0(hit_vec)
    ) else $error("tlb: multiple entries match vaddr %h", tlb_vaddr);

endmodule

// File: data_ram.sv
`timescale 1ns/10ps

module data_ram import mmu_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic      clk,
    input  logic      arst_n,

    input  logic      bus_en,
    input  byte_en_t  bus_wen,
    input  addr_t     bus_paddr,
    input  word_t     bus_wdata,
    input  axi_size_t bus_size,
    input  logic      bus_cached,
    output word_t     bus_rdata,
    output logic      bus_streq
);

    localparam int AW = $clog2(RAM_WORDS);

    word_t         mem [RAM_WORDS];
    logic [AW-1:0] idx;     // word address, wraps at RAM_WORDS
    logic          done;    // access completes this cycle
    wait_state_t   ws_q;
    wait_state_t   ws_d;

    assign idx = bus_paddr[AW+1:2];

    // uncached: stall in the first two cycles, finish in the third
    assign bus_streq = bus_en && !bus_cached && (ws_q != WS_WAIT2);
    assign done      = bus_en && !bus_streq;

    always_comb begin
        ws_d = ws_q;
        case (ws_q)
            WS_IDLE: begin
                if (bus_en && !bus_cached) begin
                    ws_d = WS_WAIT1;
                end
            end
            WS_WAIT1: ws_d = bus_en ? WS_WAIT2 : WS_IDLE;  // dropped request
            WS_WAIT2: ws_d = WS_IDLE;
            default:  ws_d = WS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ws_q <= WS_IDLE;
        end else begin
            ws_q <= ws_d;
        end
    end

    // byte merge on completion
    always_ff @(posedge clk) begin
        if (done) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_wen[b]) begin
                    mem[idx][8*b +: 8] <= bus_wdata[8*b +: 8];
                end
            end
        end
    end

    assign bus_rdata = mem[idx];  // whole word, sized by the core

    // master holds the request through the wait states
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        bus_streq |=> bus_en && $stable(bus_paddr) && $stable(bus_cached)
    ) else $error("data_ram: request changed while stalled");

    a_size_wen: assert property (
        @(posedge clk) disable iff (!arst_n)
        (bus_en && bus_wen != '0) |->
            (bus_size == SIZE_BYTE && $countones(bus_wen) == 1)
         || (bus_size == SIZE_HALF && $countones(bus_wen) == 2)
         || (bus_size == SIZE_WORD && bus_wen == 4'b1111)
    ) else $error("data_ram: size %0d does not fit wen %b", bus_size, bus_wen);

endmodule

// File: mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top import mmu_pkg::*; #(
    parameter  int TLB_ENTRIES = 8,
    parameter  int RAM_WORDS   = 1024,
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES)
) (
    input  logic                 clk,
    input  logic                 arst_n,

    // core side
    input  logic                 en,
    input  byte_en_t             wen,
    input  addr_t                vaddr,
    input  word_t                wdata,
    output word_t                rdata,
    input  axi_size_t            size,
    input  logic                 exc_flag,
    output logic                 exc_tlbr,
    output logic                 exc_tlbi,
    output logic                 exc_tlbm,
    output logic                 stallreq,

    // cp0 state
    input  logic                 erl,
    input  cattr_t               k0,
    input  cattr_t               k23,
    input  cattr_t               ku,
    input  asid_t                asid,

    // tlb write port
    input  logic                 tlb_we,
    input  logic [TLB_IDX_W-1:0] tlb_index,
    input  vpn2_t                tlb_vpn2,
    input  asid_t                tlb_asid,
    input  logic                 tlb_g,
    input  pfn_t                 tlb_pfn0,
    input  cattr_t               tlb_c0,
    input  logic                 tlb_d0,
    input  logic                 tlb_v0,
    input  pfn_t                 tlb_pfn1,
    input  cattr_t               tlb_c1,
    input  logic                 tlb_d1,
    input  logic                 tlb_v1
);

    // mmu to ram
    logic      bus_en;
    byte_en_t  bus_wen;
    addr_t     bus_paddr;
    word_t     bus_wdata;
    word_t     bus_rdata;
    axi_size_t bus_size;
    logic      bus_streq;
    logic      bus_cached;

    // mmu to tlb
    logic      tlb_en;
    addr_t     tlb_vaddr;
    logic      tlb_refs;
    logic      tlb_rdy;
    addr_t     tlb_paddr;
    logic      tlb_cat;
    logic      tlb_tlbr;
    logic      tlb_tlbi;
    logic      tlb_tlbm;

    // port names match the nets above
    mmu i_mmu (.*);

    tlb #(.TLB_ENTRIES(TLB_ENTRIES)) i_tlb (.*);

    data_ram #(.RAM_WORDS(RAM_WORDS)) i_data_ram (.*);

endmodule

// File: tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys import mmu_pkg::*; ();

    localparam int TLB_ENTRIES = 8;
    localparam int RAM_WORDS   = 1024;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);
    localparam int AW          = $clog2(RAM_WORDS);
    localparam int MAX_CYCLES  = 3000;  // tests take about 1300 cycles

    logic             clk;
    logic             arst_n;
    logic             en;
    byte_en_t         wen;
    addr_t            vaddr;
    word_t            wdata;
    word_t            rdata;
    axi_size_t        size;
    logic             exc_flag;
    logic             exc_tlbr;
    logic             exc_tlbi;
    logic             exc_tlbm;
    logic             stallreq;
    logic             erl;
    cattr_t           k0;
    cattr_t           k23;
    cattr_t           ku;
    asid_t            asid;
    logic             tlb_we;
    logic [IDX_W-1:0] tlb_index;
    vpn2_t            tlb_vpn2;
    asid_t            tlb_asid;
    logic             tlb_g;
    pfn_t             tlb_pfn0;
    cattr_t           tlb_c0;
    logic             tlb_d0;
    logic             tlb_v0;
    pfn_t             tlb_pfn1;
    cattr_t           tlb_c1;
    logic             tlb_d1;
    logic             tlb_v1;

    // expected response of the access in flight
    int               exp_stall;
    logic [2:0]       exp_exc;    // {tlbr, tlbi, tlbm}
    word_t            exp_rdata;
    logic             chk_rd;

    // shadow ram and shadow tlb table
    word_t            sh_mem  [RAM_WORDS];
    bit               known   [RAM_WORDS];
    vpn2_t            sh_vpn2 [TLB_ENTRIES];
    asid_t            sh_asid [TLB_ENTRIES];
    logic             sh_g    [TLB_ENTRIES];
    pfn_t             sh_pfn0 [TLB_ENTRIES];
    pfn_t             sh_pfn1 [TLB_ENTRIES];
    cattr_t           sh_c0   [TLB_ENTRIES];
    cattr_t           sh_c1   [TLB_ENTRIES];
    logic             sh_d0   [TLB_ENTRIES];
    logic             sh_d1   [TLB_ENTRIES];
    logic             sh_v0   [TLB_ENTRIES];
    logic             sh_v1   [TLB_ENTRIES];
    bit [TLB_ENTRIES-1:0] sh_used;

    int seed      = 89;
    int errors    = 0;
    int n_access  = 0;
    int stall_cnt = 0;
    int cycle_cnt = 0;

    mem_subsys_top #(
        .TLB_ENTRIES(TLB_ENTRIES),
        .RAM_WORDS  (RAM_WORDS)
    ) i_mem_subsys_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // stall cycles seen so far by the current request
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_cnt <= 0;
        end else if (en && stallreq) begin
            stall_cnt <= stall_cnt + 1;
        end else begin
            stall_cnt <= 0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (arst_n && en && !stallreq) begin
            n_access <= n_access + 1;
        end
    end

    a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
        (en && !stallreq && chk_rd) |-> rdata == exp_rdata)
    else begin
        errors++;
        $display("MISMATCH at %0t: rdata got %h expected %h",
                 $time, $sampled(rdata), $sampled(exp_rdata));
    end

    a_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (en && !stallreq) |-> stall_cnt == exp_stall)
    else begin
        errors++;
        $display("MISMATCH at %0t: stallreq cycles got %0d expected %0d",
                 $time, $sampled(stall_cnt), $sampled(exp_stall));
    end

    a_exc: assert property (@(posedge clk) disable iff (!arst_n)
        (en && !stallreq) |-> {exc_tlbr, exc_tlbi, exc_tlbm} == exp_exc)
    else begin
        errors++;
        $display("MISMATCH at %0t: {exc_tlbr,exc_tlbi,exc_tlbm} got %b expected %b",
                 $time, $sampled({exc_tlbr, exc_tlbi, exc_tlbm}), $sampled(exp_exc));
    end

    a_exc_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !en |-> !(exc_tlbr || exc_tlbi || exc_tlbm))
    else begin
        errors++;
        $display("tlb exception raised at %0t with no request pending", $time);
    end

    function automatic word_t rnd();
        return $random(seed);
    endfunction

    function automatic byte_en_t rand_be();
        word_t r;
        r = rnd();
        case (r[3:2])
            2'd0:    return byte_en_t'(4'b0001 << r[1:0]);
            2'd1:    return r[0] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic axi_size_t size_of(input byte_en_t be);
        case ($countones(be))
            1:       return SIZE_BYTE;
            2:       return SIZE_HALF;
            default: return SIZE_WORD;  // full word store or load
        endcase
    endfunction

    // low bits carry the index so every entry has its own vpn2
    function automatic vpn2_t make_vpn2(input int i);
        word_t r;
        r = rnd();
        return {i[0] ? 2'b11 : {1'b0, r[0]}, r[16-IDX_W:0], i[IDX_W-1:0]};
    endfunction

    // expected translation, stall and exception of one access
    function automatic void predict(input addr_t va, input logic store, input logic cancel,
                                    output addr_t pa, output int stall,
                                    output logic [2:0] exc, output logic writes);
        seg_t   seg;
        logic   mapped;
        int     hit;
        pfn_t   pfn;
        cattr_t c;
        logic   d;
        logic   v;
        seg    = va[31:29];
        pa     = {3'b000, va[28:0]};
        exc    = 3'b000;
        hit    = -1;
        mapped = !erl && seg != SEG_KSEG0 && seg != SEG_KSEG1;
        if (!mapped) begin
            stall = (seg == SEG_KSEG0 && !erl && k0 == CATTR_CACHED) ? 0 : 2;
        end else begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (sh_used[i] && sh_vpn2[i] == va[31:13]
                        && (sh_g[i] || sh_asid[i] == asid)) begin
                    hit = i;
                end
            end
            stall = 1;  // lookup wait
            if (hit < 0) begin
                exc = 3'b100;
            end else begin
                if (va[12]) begin
                    pfn = sh_pfn1[hit];
                    c   = sh_c1[hit];
                    d   = sh_d1[hit];
                    v   = sh_v1[hit];
                end else begin
                    pfn = sh_pfn0[hit];
                    c   = sh_c0[hit];
                    d   = sh_d0[hit];
                    v   = sh_v0[hit];
                end
                if (!v) begin
                    exc = 3'b010;
                end else if (store && !d) begin
                    exc = 3'b001;
                end else begin
                    pa = {pfn, va[11:0]};
                    if (c != CATTR_CACHED) begin
                        stall = 3;
                    end
                end
            end
        end
        // cancelled access never reaches the ram
        if (cancel && exc == 3'b000) begin
            stall = mapped ? 1 : 0;
        end
        writes = store && !cancel && exc == 3'b000;
    endfunction

    task automatic access(input addr_t va, input byte_en_t be, input word_t wd,
                          input logic cancel, output addr_t pa);
        int         stall;
        logic [2:0] exc;
        logic       writes;
        int         w;
        @(posedge clk);
        predict(va, be != '0, cancel, pa, stall, exc, writes);
        w = int'(pa[AW+1:2]);
        en        <= 1'b1;
        vaddr     <= va;
        wen       <= be;
        wdata     <= wd;
        size      <= size_of(be);
        exc_flag  <= cancel;
        exp_stall <= stall;
        exp_exc   <= exc;
        exp_rdata <= sh_mem[w];
        chk_rd    <= (be == '0) && (exc == 3'b000) && known[w];
        @(negedge clk);
        while (stallreq) begin
            @(negedge clk);
        end
        @(posedge clk);  // completes here
        en       <= 1'b0;
        wen      <= '0;
        exc_flag <= 1'b0;
        chk_rd   <= 1'b0;
        if (writes) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    sh_mem[w][8*b +: 8] = wd[8*b +: 8];
                end
            end
            if (be == 4'b1111) begin
                known[w] = 1'b1;
            end
        end
    endtask

    task automatic set_cp0(input logic erl_v, input cattr_t k0_v, input asid_t asid_v);
        @(posedge clk);
        erl  <= erl_v;
        k0   <= k0_v;
        asid <= asid_v;
    endtask

    task automatic write_entry(input int idx, input vpn2_t vpn2, input asid_t asid_v,
                               input logic g, input logic v0, input logic d0,
                               input logic v1, input logic d1);
        word_t r0;
        word_t r1;
        r0 = rnd();
        r1 = rnd();
        @(posedge clk);
        tlb_we    <= 1'b1;
        tlb_index <= idx[IDX_W-1:0];
        tlb_vpn2  <= vpn2;
        tlb_asid  <= asid_v;
        tlb_g     <= g;
        tlb_pfn0  <= r0[19:0];
        tlb_c0    <= r0[31] ? CATTR_CACHED : CATTR_UNCACHED;
        tlb_d0    <= d0;
        tlb_v0    <= v0;
        tlb_pfn1  <= r1[19:0];
        tlb_c1    <= r1[31] ? CATTR_CACHED : CATTR_UNCACHED;
        tlb_d1    <= d1;
        tlb_v1    <= v1;
        @(posedge clk);
        tlb_we <= 1'b0;
        sh_vpn2[idx] = vpn2;
        sh_asid[idx] = asid_v;
        sh_g[idx]    = g;
        sh_pfn0[idx] = r0[19:0];
        sh_c0[idx]   = r0[31] ? CATTR_CACHED : CATTR_UNCACHED;
        sh_d0[idx]   = d0;
        sh_v0[idx]   = v0;
        sh_pfn1[idx] = r1[19:0];
        sh_c1[idx]   = r1[31] ? CATTR_CACHED : CATTR_UNCACHED;
        sh_d1[idx]   = d1;
        sh_v1[idx]   = v1;
        sh_used[idx] = 1'b1;
    endtask

    // full word, byte merge, read, then read back the physical word through kseg0
    task automatic check_rw(input addr_t wr_va, input addr_t rd_va);
        addr_t pa;
        addr_t pa_rd;
        access(wr_va, 4'b1111, rnd(), 1'b0, pa);
        access(wr_va, rand_be(), rnd(), 1'b0, pa);
        access(rd_va, 4'b0000, '0, 1'b0, pa_rd);
        access({3'b100, pa[28:0]}, 4'b0000, '0, 1'b0, pa_rd);
    endtask

    task automatic fault_check(input addr_t va, input addr_t pa);
        addr_t unused_pa;
        access({3'b100, pa[28:0]}, 4'b1111, rnd(), 1'b0, unused_pa);
        access(va, 4'b1111, rnd(), 1'b0, unused_pa);
        access(va, 4'b0000, '0, 1'b0, unused_pa);
        access({3'b100, pa[28:0]}, 4'b0000, '0, 1'b0, unused_pa);
    endtask

    task automatic cancel_check(input addr_t va);
        addr_t pa;
        addr_t unused_pa;
        access(va, 4'b1111, rnd(), 1'b0, pa);
        access(va, 4'b1111, rnd(), 1'b1, pa);  // store dropped
        access({3'b100, pa[28:0]}, 4'b0000, '0, 1'b0, unused_pa);
    endtask

    task automatic report_counts();
        $display("summary: %0d accesses checked, %0d errors", n_access, errors);
    endtask

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        report_counts();
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        word_t a;
        addr_t va;
        arst_n    = 1'b0;
        en        = 1'b0;
        wen       = '0;
        vaddr     = '0;
        wdata     = '0;
        size      = SIZE_WORD;
        exc_flag  = 1'b0;
        erl       = 1'b0;
        k0        = CATTR_CACHED;
        k23       = CATTR_CACHED;
        ku        = CATTR_CACHED;
        asid      = '0;
        tlb_we    = 1'b0;
        tlb_index = '0;
        tlb_vpn2  = '0;
        tlb_asid  = '0;
        tlb_g     = 1'b0;
        tlb_pfn0  = '0;
        tlb_c0    = '0;
        tlb_d0    = 1'b0;
        tlb_v0    = 1'b0;
        tlb_pfn1  = '0;
        tlb_c1    = '0;
        tlb_d1    = 1'b0;
        tlb_v1    = 1'b0;
        exp_stall = 0;
        exp_exc   = 3'b000;
        exp_rdata = '0;
        chk_rd    = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        set_cp0(1'b0, CATTR_CACHED, 8'h11);
        repeat (24) begin
            a  = rnd();
            va = {3'b100, a[28:2], 2'b00};
            check_rw(va, va);
        end

        // kseg1 writes alias the kseg0 reads
        repeat (16) begin
            a = rnd();
            check_rw({3'b101, a[28:2], 2'b00}, {3'b100, a[28:2], 2'b00});
        end
        set_cp0(1'b0, CATTR_UNCACHED, 8'h11);
        repeat (16) begin
            a  = rnd();
            va = {3'b100, a[28:2], 2'b00};
            check_rw(va, va);
        end

        // mapped hits with the global bit on entries 2, 3, 6 and 7
        set_cp0(1'b0, CATTR_CACHED, 8'h11);
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            a = rnd();
            write_entry(i, make_vpn2(i), i[1] ? a[7:0] : 8'h11, i[1], 1'b1, 1'b1, 1'b1, 1'b1);
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            for (int p = 0; p < 2; p++) begin
                a  = rnd();
                va = {sh_vpn2[i], p[0], a[11:2], 2'b00};
                check_rw(va, va);
            end
        end

        // wrong asid, then an unmatched vpn
        a = rnd();
        set_cp0(1'b0, CATTR_CACHED, 8'h22);
        fault_check({sh_vpn2[0], 1'b0, a[11:2], 2'b00}, {sh_pfn0[0], a[11:2], 2'b00});
        set_cp0(1'b0, CATTR_CACHED, 8'h11);
        fault_check({sh_vpn2[0] ^ vpn2_t'(1 << IDX_W), 1'b0, a[11:2], 2'b00},
                    {sh_pfn0[0], a[11:2], 2'b00});
        // even page invalid, odd page clean
        write_entry(6, make_vpn2(6), 8'h11, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        fault_check({sh_vpn2[6], 1'b0, a[11:2], 2'b00}, {sh_pfn0[6], a[11:2], 2'b00});
        fault_check({sh_vpn2[6], 1'b1, a[11:2], 2'b00}, {sh_pfn1[6], a[11:2], 2'b00});

        set_cp0(1'b1, CATTR_CACHED, 8'h11);
        repeat (8) begin
            a  = rnd();
            va = a[31] ? {3'b110, a[28:2], 2'b00} : {1'b0, a[30:2], 2'b00};
            check_rw(va, va);
        end

        set_cp0(1'b0, CATTR_CACHED, 8'h11);
        repeat (3) begin
            a = rnd();
            cancel_check({3'b100, a[28:2], 2'b00});
            cancel_check({sh_vpn2[0], 1'b0, a[11:2], 2'b00});
        end

        repeat (2) @(posedge clk);
        report_counts();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
mmu_pkg.sv
mmu.sv
tlb.sv
data_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module tb_mem_subsys \
    -Mdir obj_dir -o sim_mem_subsys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0
